/* logic/core_pkg.sv */
`default_nettype none

package core_pkg;

	// instruction layout, three 4-bit fields
	localparam int tag_width   = 4;                 // every field is one tag wide
	localparam int data_width  = 8;                 // operand and result width
	localparam int instr_width = 3 * tag_width;     // opcode, addr a, addr b

	// alu opcodes, top field of the instruction
	typedef enum logic [tag_width-1:0] {
		op_add  = 4'h0,                             // a + b, carry out
		op_sub  = 4'h1,                             // a - b, borrow out
		op_and  = 4'h2,                             // bitwise and
		op_or   = 4'h3,                             // bitwise or
		op_xor  = 4'h4,                             // bitwise xor
		op_pass = 4'h5                              // result is operand a
	} alu_op_e;                                     // other codes give 0

	// core sequencer
	typedef enum logic [2:0] {
		st_idle,                                    // waiting for a strobe
		st_req,                                     // bus requested, addr a out once granted
		st_read_a,                                  // capture a, addr b out
		st_read_b,                                  // capture b, release bus
		st_exec                                     // register alu result
	} core_state_e;

endpackage

`default_nettype wire

/* logic/mem_pkg.sv */
`default_nettype none

package mem_pkg;

	// l2 geometry
	localparam int l2_entries    = 16;                 // shared data array depth
	localparam int l2_addr_width = $clog2(l2_entries); // 4 address bits

	// reset pattern, entry i = low byte of i*mult + add
	localparam int l2_init_mult = 37;
	localparam int l2_init_add  = 11;

	// arbiter states
	typedef enum logic [1:0] {
		arb_idle,                                      // nobody owns the bus
		arb_grant1,                                    // core 1 owns the bus
		arb_grant2                                     // core 2 owns the bus
	} arb_state_e;

endpackage

`default_nettype wire

/* logic/processor.sv */
`default_nettype none

module processor (
	input  logic                              clk,                  // system clock
	input  logic                              rst_n,                // sync reset, active low
	input  logic [core_pkg::instr_width-1:0]  vector_in,            // opcode, addr a, addr b
	input  logic                              fetching,             // one-cycle start strobe
	input  logic                              bus_grant,            // from arbiter, registered
	input  logic [core_pkg::data_width-1:0]   data_in,              // shared l2 read data
	output logic                              bus_request,          // to arbiter
	output logic [mem_pkg::l2_addr_width-1:0] addr_out,             // l2 read address
	output logic                              status_out,           // high while busy
	output logic [core_pkg::data_width-1:0]   alu_out,              // registered result
	output logic                              alu_carry_output,     // carry or borrow
	output logic                              alu_zero_flag_output  // result was zero
);
	import core_pkg::*;

	core_state_e            state;      // fetch sequencer
	logic [instr_width-1:0] instr_q;    // accepted instruction
	alu_op_e                opcode;     // top field of instr_q
	logic [tag_width-1:0]   addr_a;     // operand a location
	logic [tag_width-1:0]   addr_b;     // operand b location
	logic [data_width-1:0]  op_a;       // fetched operand a
	logic [data_width-1:0]  op_b;       // fetched operand b
	logic [data_width:0]    sum;        // add with ninth bit
	logic [data_width-1:0]  alu_res;    // comb alu result
	logic                   alu_carry;  // comb alu carry

	// instruction fields
	assign opcode = alu_op_e'(instr_q[instr_width-1 -: tag_width]);
	assign addr_a = instr_q[2*tag_width-1 -: tag_width];
	assign addr_b = instr_q[tag_width-1:0];

	assign status_out  = (state != st_idle);                   // busy until exec done
	assign bus_request = (state == st_req) || (state == st_read_a) || (state == st_read_b);
	assign addr_out    = (state == st_req) ? addr_a : addr_b;  // a first, then b

	// alu, only registered in st_exec
	always_comb begin
		sum       = {1'b0, op_a} + {1'b0, op_b};
		alu_res   = '0;
		alu_carry = 1'b0;
		case (opcode)
			op_add: begin
				alu_res   = sum[data_width-1:0];
				alu_carry = sum[data_width];       // ninth sum bit
			end
			op_sub: begin
				alu_res   = op_a - op_b;
				alu_carry = (op_a < op_b);         // borrow
			end
			op_and:  alu_res = op_a & op_b;
			op_or:   alu_res = op_a | op_b;
			op_xor:  alu_res = op_a ^ op_b;
			op_pass: alu_res = op_a;
			default: alu_res = '0;                 // undefined opcode
		endcase
	end

	// control and result flags
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state                <= st_idle;
			alu_out              <= '0;
			alu_carry_output     <= 1'b0;
			alu_zero_flag_output <= 1'b1;          // zero result after reset
		end else begin
			case (state)
				st_idle: begin
					if (fetching) begin
						state <= st_req;           // strobe ignored while busy
					end
				end
				st_req: begin
					if (bus_grant) begin
						state <= st_read_a;        // l2 samples addr a now
					end
				end
				st_read_a: begin
					if (bus_grant) begin
						state <= st_read_b;
					end
				end
				st_read_b: begin
					if (bus_grant) begin
						state <= st_exec;          // request drops next cycle
					end
				end
				st_exec: begin
					alu_out              <= alu_res;
					alu_carry_output     <= alu_carry;
					alu_zero_flag_output <= (alu_res == '0);
					state                <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// instruction and operand capture
	always_ff @(posedge clk) begin
		if (state == st_idle && fetching) begin
			instr_q <= vector_in;
		end
		if (state == st_read_a && bus_grant) begin
			op_a <= data_in;                       // only the granted core samples
		end
		if (state == st_read_b && bus_grant) begin
			op_b <= data_in;
		end
	end

endmodule

`default_nettype wire

/* logic/l2_cache.sv */
`default_nettype none

module l2_cache (
	input  logic                              clk,      // system clock
	input  logic                              rst_n,    // sync reset, loads pattern
	input  logic                              rd_en,    // read strobe from granted core
	input  logic [mem_pkg::l2_addr_width-1:0] rd_addr,  // entry select
	output logic [core_pkg::data_width-1:0]   rd_data   // one cycle after rd_en
);
	import core_pkg::*;
	import mem_pkg::*;

	logic [data_width-1:0] mem [l2_entries];            // shared data array

	// pattern load, array is read-only afterwards
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < l2_entries; i++) begin
				mem[i] <= data_width'(i * l2_init_mult + l2_init_add); // low byte kept
			end
		end
	end

	// registered read port
	// value holds while rd_en is low
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];                    // latency 1
		end
	end

endmodule

`default_nettype wire

/* logic/bus_arbiter.sv */
`default_nettype none

module bus_arbiter (
	input  logic clk,       // system clock
	input  logic rst_n,     // sync reset, active low
	input  logic request1,  // core 1 wants the l2
	input  logic request2,  // core 2 wants the l2
	output logic grant1,    // core 1 owns the l2
	output logic grant2     // core 2 owns the l2
);
	import mem_pkg::*;

	arb_state_e state;         // current owner
	arb_state_e next_state;
	logic       last_served2;  // core 2 was granted most recently

	always_comb begin
		next_state = state;
		case (state)
			arb_idle: begin
				if (request1 && request2) begin
					next_state = last_served2 ? arb_grant1 : arb_grant2; // alternate
				end else if (request1) begin
					next_state = arb_grant1;
				end else if (request2) begin
					next_state = arb_grant2;
				end
			end
			arb_grant1: begin
				if (!request1) begin
					next_state = request2 ? arb_grant2 : arb_idle;  // hand over if waiting
				end
			end
			arb_grant2: begin
				if (!request2) begin
					next_state = request1 ? arb_grant1 : arb_idle;
				end
			end
			default: next_state = arb_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state        <= arb_idle;
			last_served2 <= 1'b1;  // core 1 wins the first tie
		end else begin
			state <= next_state;
			if (next_state == arb_grant1) begin
				last_served2 <= 1'b0;
			end else if (next_state == arb_grant2) begin
				last_served2 <= 1'b1;
			end
		end
	end

	// grants decode the state register, so they are registered
	assign grant1 = (state == arb_grant1);
	assign grant2 = (state == arb_grant2);

endmodule

`default_nettype wire

/* logic/dualcore.sv */
`default_nettype none

module dualcore (
	input  logic                             clk,                    // system clock
	input  logic                             rst_n,                  // sync reset, active low
	input  logic [core_pkg::instr_width-1:0] vector_in1,             // instruction for core 1
	input  logic [core_pkg::instr_width-1:0] vector_in2,             // instruction for core 2
	input  logic                             fetching1,              // start strobe core 1
	input  logic                             fetching2,              // start strobe core 2
	output logic                             status_out1,            // core 1 busy
	output logic                             status_out2,            // core 2 busy
	output logic [core_pkg::data_width-1:0]  alu_out1,               // core 1 result
	output logic [core_pkg::data_width-1:0]  alu_out2,               // core 2 result
	output logic                             alu_carry_output1,      // core 1 carry
	output logic                             alu_carry_output2,      // core 2 carry
	output logic                             alu_zero_flag_output1,  // core 1 zero
	output logic                             alu_zero_flag_output2   // core 2 zero
);
	import core_pkg::*;
	import mem_pkg::*;

	logic                     request1;  // core 1 to arbiter
	logic                     request2;  // core 2 to arbiter
	logic                     grant1;    // arbiter to core 1
	logic                     grant2;    // arbiter to core 2
	logic [l2_addr_width-1:0] addr1;     // core 1 address
	logic [l2_addr_width-1:0] addr2;     // core 2 address
	logic [l2_addr_width-1:0] l2_addr;   // steered address
	logic                     l2_rd_en;  // steered read enable
	logic [data_width-1:0]    l2_data;   // fans out to both cores

	// grant-steered bus mux, owner drives address and enable
	always_comb begin
		l2_addr  = addr1;
		l2_rd_en = 1'b0;
		if (grant1) begin
			l2_addr  = addr1;
			l2_rd_en = request1;  // low in the cycle the grant is released
		end else if (grant2) begin
			l2_addr  = addr2;
			l2_rd_en = request2;
		end
	end

	processor u_core1 (
		.clk(clk), .rst_n(rst_n), .vector_in(vector_in1), .fetching(fetching1),
		.bus_grant(grant1), .data_in(l2_data), .bus_request(request1), .addr_out(addr1),
		.status_out(status_out1), .alu_out(alu_out1), .alu_carry_output(alu_carry_output1),
		.alu_zero_flag_output(alu_zero_flag_output1)
	);

	processor u_core2 (
		.clk(clk), .rst_n(rst_n), .vector_in(vector_in2), .fetching(fetching2),
		.bus_grant(grant2), .data_in(l2_data), .bus_request(request2), .addr_out(addr2),
		.status_out(status_out2), .alu_out(alu_out2), .alu_carry_output(alu_carry_output2),
		.alu_zero_flag_output(alu_zero_flag_output2)
	);

	bus_arbiter u_arbiter (
		.clk(clk), .rst_n(rst_n), .request1(request1), .request2(request2),
		.grant1(grant1), .grant2(grant2)
	);

	l2_cache u_l2 (
		.clk(clk), .rst_n(rst_n), .rd_en(l2_rd_en), .rd_addr(l2_addr), .rd_data(l2_data)
	);

endmodule

`default_nettype wire

/* verif/dualcore_props.sv */
`default_nettype none

module dualcore_props (
	input logic clk,       // arbiter clock
	input logic rst_n,     // sync reset, active low
	input logic request1,  // core 1 request
	input logic request2,  // core 2 request
	input logic grant1,    // core 1 grant
	input logic grant2     // core 2 grant
);

	// one owner on the l2 bus
	grants_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(grant1 && grant2))
		else $error("grant1 and grant2 high together");

	// a grant only rises for a waiting core
	grant1_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(grant1) |-> request1)
		else $error("grant1 rose without request1");

	grant2_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(grant2) |-> request2)
		else $error("grant2 rose without request2");

	// arbiter comes out of reset idle
	no_grant_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> (!grant1 && !grant2))
		else $error("grant high in the first cycle after reset");

endmodule

bind bus_arbiter dualcore_props u_props (
	.clk(clk), .rst_n(rst_n), .request1(request1), .request2(request2),
	.grant1(grant1), .grant2(grant2)
);

`default_nettype wire

/* verif/dualcore_checker.sv */
`default_nettype none

module dualcore_checker (
	input  logic                             clk,          // sampled on the rising edge
	input  logic                             rst_n,        // aborts operations in flight
	input  logic [2:0]                       test_id,      // phase tag from the testbench
	input  logic [core_pkg::instr_width-1:0] vector_in1,
	input  logic [core_pkg::instr_width-1:0] vector_in2,
	input  logic                             fetching1,
	input  logic                             fetching2,
	input  logic                             status_out1,
	input  logic                             status_out2,
	input  logic [core_pkg::data_width-1:0]  alu_out1,
	input  logic [core_pkg::data_width-1:0]  alu_out2,
	input  logic                             carry1,
	input  logic                             carry2,
	input  logic                             zero1,
	input  logic                             zero2,
	output int                               checked,      // operations compared
	output int                               errors        // wrong results and latencies
);
	import core_pkg::*;
	import mem_pkg::*;

	logic                   pending  [2] = '{1'b0, 1'b0};  // operation in flight per core
	logic [instr_width-1:0] accepted [2];                  // instruction the core took
	logic [2:0]             phase_q  [2];                  // phase at acceptance
	int                     cycles   [2];                  // edges since acceptance
	int                     n_checked = 0;
	int                     n_errors  = 0;

	assign checked = n_checked;
	assign errors  = n_errors;

	// l2 contents after reset
	function automatic logic [data_width-1:0] l2_entry(input logic [tag_width-1:0] addr);
		return data_width'(int'(addr) * l2_init_mult + l2_init_add);
	endfunction

	// reference alu, returns {carry, zero, result}
	function automatic logic [data_width+1:0] expected_alu(input logic [instr_width-1:0] instr);
		int   a;
		int   b;
		int   s;
		logic c;
		a = int'(l2_entry(instr[2*tag_width-1 -: tag_width]));
		b = int'(l2_entry(instr[tag_width-1:0]));
		s = 0;
		c = 1'b0;
		case (instr[instr_width-1 -: tag_width])
			op_add: begin
				s = a + b;
				c = (s >= (1 << data_width));  // overflow past 8 bits
			end
			op_sub: begin
				s = a - b;
				c = (s < 0);                   // borrow
			end
			op_and:  s = a & b;
			op_or:   s = a | b;
			op_xor:  s = a ^ b;
			op_pass: s = a;
			default: s = 0;                    // undefined opcode
		endcase
		return {c, (data_width'(s) == '0), data_width'(s)};
	endfunction

	function automatic string phase_name(input logic [2:0] id);
		case (id)
			3'd1:    return "single_op";
			3'd2:    return "core2_op";
			3'd3:    return "contention";
			3'd4:    return "ignored_strobe";
			3'd5:    return "random";
			3'd6:    return "reset_recover";
			default: return "misc";
		endcase
	endfunction

	task automatic watch_core(input int idx, input logic strobe, input logic busy,
			input logic [instr_width-1:0] vin, input logic [data_width-1:0] res,
			input logic carry, input logic zero);
		logic [data_width+1:0] exp;
		string                 name;
		if (!rst_n) begin
			pending[idx] = 1'b0;                   // aborted, nothing to compare
		end else begin
			if (pending[idx]) begin
				cycles[idx]++;
				if (!busy) begin                   // status fell, result is valid
					exp  = expected_alu(accepted[idx]);
					name = $sformatf("%s core%0d", phase_name(phase_q[idx]), idx + 1);
					n_checked++;
					if ({carry, zero, res} !== exp) begin
						n_errors++;
						$display("FAIL %s instr %h expected c=%b z=%b res=%h actual c=%b z=%b res=%h",
							name, accepted[idx], exp[data_width+1], exp[data_width],
							exp[data_width-1:0], carry, zero, res);
					end else if (phase_q[idx] inside {3'd1, 3'd2} && cycles[idx] != 6) begin
						n_errors++;                    // no contention, fixed latency
						$display("FAIL %s latency expected 6 actual %0d", name, cycles[idx]);
					end else begin
						$display("ok   %s instr %h res=%h c=%b z=%b cycles=%0d",
							name, accepted[idx], res, carry, zero, cycles[idx]);
					end
					pending[idx] = 1'b0;
				end
			end
			if (strobe && !busy) begin             // strobe while busy is dropped
				pending[idx]  = 1'b1;
				accepted[idx] = vin;
				phase_q[idx]  = test_id;
				cycles[idx]   = 0;
			end
		end
	endtask

	// pre-edge values, outputs are all registered
	always @(posedge clk) begin
		watch_core(0, fetching1, status_out1, vector_in1, alu_out1, carry1, zero1);
		watch_core(1, fetching2, status_out2, vector_in2, alu_out2, carry2, zero2);
	end

endmodule

`default_nettype wire

/* verif/dualcore_tb.sv */
`default_nettype none

module dualcore_tb;
	import core_pkg::*;

	logic                   clk;
	logic                   rst_n;
	logic [instr_width-1:0] vector_in1;
	logic [instr_width-1:0] vector_in2;
	logic                   fetching1;
	logic                   fetching2;
	logic                   status_out1;
	logic                   status_out2;
	logic [data_width-1:0]  alu_out1;
	logic [data_width-1:0]  alu_out2;
	logic                   carry1;
	logic                   carry2;
	logic                   zero1;
	logic                   zero2;
	logic [2:0]             test_id;              // phase tag for the checker
	int                     checked;
	int                     chk_errors;
	int                     tb_errors;
	logic                   run_done  = 1'b0;
	logic                   timed_out = 1'b0;
	logic                   verdict   = 1'b0;     // summary already printed

	// carry, borrow, zero and undefined opcode cases
	logic [instr_width-1:0] sweep [10] = '{12'h065, 12'h001, 12'h101, 12'h133, 12'h22a,
		12'h35c, 12'h444, 12'h59f, 12'ha12, 12'hf77};

	always #4 clk = ~clk;                         // period 8

	dualcore u_dut (
		.clk(clk), .rst_n(rst_n), .vector_in1(vector_in1), .vector_in2(vector_in2),
		.fetching1(fetching1), .fetching2(fetching2), .status_out1(status_out1),
		.status_out2(status_out2), .alu_out1(alu_out1), .alu_out2(alu_out2),
		.alu_carry_output1(carry1), .alu_carry_output2(carry2),
		.alu_zero_flag_output1(zero1), .alu_zero_flag_output2(zero2)
	);

	dualcore_checker u_checker (
		.clk(clk), .rst_n(rst_n), .test_id(test_id), .vector_in1(vector_in1),
		.vector_in2(vector_in2), .fetching1(fetching1), .fetching2(fetching2),
		.status_out1(status_out1), .status_out2(status_out2), .alu_out1(alu_out1),
		.alu_out2(alu_out2), .carry1(carry1), .carry2(carry2), .zero1(zero1),
		.zero2(zero2), .checked(checked), .errors(chk_errors)
	);

	// core 0 means either core
	function automatic logic busy(input int core);
		return (core != 2 && status_out1) || (core != 1 && status_out2);
	endfunction

	task automatic strobe_core(input int core, input logic [instr_width-1:0] instr);
		if (core == 1) begin
			vector_in1 = instr;
			fetching1  = 1'b1;
		end else begin
			vector_in2 = instr;
			fetching2  = 1'b1;
		end
		@(negedge clk);
		fetching1 = 1'b0;                         // one-cycle strobe
		fetching2 = 1'b0;
	endtask

	task automatic strobe_both(input logic [instr_width-1:0] instr1,
			input logic [instr_width-1:0] instr2);
		vector_in1 = instr1;
		vector_in2 = instr2;
		fetching1  = 1'b1;
		fetching2  = 1'b1;
		@(negedge clk);
		fetching1 = 1'b0;
		fetching2 = 1'b0;
	endtask

	task automatic wait_idle(input int core, input int limit);
		int cnt;
		cnt = 0;
		while (busy(core) && cnt < limit) begin
			@(negedge clk);
			cnt++;
		end
		if (busy(core)) begin
			$display("timeout: core %0d still busy after %0d cycles", core, limit);
			timed_out = 1'b1;
			run_done  = 1'b1;
		end
	endtask

	// idle, carry 0, zero 1, result 0
	task automatic check_cleared(input string name);
		logic [10:0] exp;
		logic [10:0] act;
		exp = {1'b0, 1'b0, 1'b1, 8'h00};
		for (int c = 1; c <= 2; c++) begin
			act = (c == 1) ? {status_out1, carry1, zero1, alu_out1}
				: {status_out2, carry2, zero2, alu_out2};
			if (act !== exp) begin
				$display("FAIL %s core%0d expected %h actual %h", name, c, exp, act);
				tb_errors++;
			end else begin
				$display("ok   %s core%0d outputs cleared", name, c);
			end
		end
	endtask

	initial begin
		int                     core;
		int                     gap;
		logic [instr_width-1:0] instr;
		void'($urandom(34));
		clk        = 1'b0;
		rst_n      = 1'b0;
		vector_in1 = '0;
		vector_in2 = '0;
		fetching1  = 1'b0;
		fetching2  = 1'b0;
		test_id    = 3'd0;
		tb_errors  = 0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_cleared("power_on_reset");
		test_id = 3'd1;                           // core 1 alone
		for (int i = 0; i < 10; i++) begin
			wait_idle(1, 20);
			strobe_core(1, sweep[i]);
		end
		wait_idle(1, 20);
		test_id = 3'd2;                           // second mux path
		for (int i = 0; i < 10; i++) begin
			wait_idle(2, 20);
			strobe_core(2, sweep[i]);
		end
		wait_idle(2, 20);
		test_id = 3'd3;                           // same-cycle strobes
		for (int i = 0; i < 8; i++) begin
			strobe_both(sweep[i], sweep[9 - i]);
			wait_idle(0, 30);
		end
		test_id = 3'd4;
		strobe_core(1, 12'h065);
		@(negedge clk);
		strobe_core(1, 12'h133);                  // lands while busy
		wait_idle(1, 20);
		test_id = 3'd5;
		for (int i = 0; i < 40; i++) begin
			core  = int'($urandom % 2) + 1;
			gap   = int'($urandom % 4);
			instr = 12'($urandom % 32'h800);      // opcodes 0..7, 6 and 7 undefined
			wait_idle(core, 40);
			repeat (gap) @(negedge clk);
			strobe_core(core, instr);
		end
		wait_idle(0, 40);
		test_id = 3'd6;
		strobe_both(12'h59f, 12'h59f);            // nonzero results before reset
		wait_idle(0, 30);
		strobe_both(12'h22a, 12'h35c);
		repeat (2) @(negedge clk);
		rst_n = 1'b0;                             // mid fetch
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		check_cleared("reset_recover");
		strobe_both(12'h065, 12'h101);
		wait_idle(0, 30);
		repeat (3) @(negedge clk);                // checker sees the last fall
		run_done = 1'b1;
	end

	initial begin
		int cnt;
		cnt = 0;
		while (!run_done && cnt < 4000) begin     // bound on the whole run
			@(negedge clk);
			cnt++;
		end
		if (!run_done) begin
			$display("timeout: run did not finish within %0d cycles", cnt);
			timed_out = 1'b1;
		end
		$display("checked %0d operations, %0d errors", checked, chk_errors + tb_errors);
		verdict = 1'b1;
		if (!timed_out && chk_errors == 0 && tb_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	// run stopped early by a failed assertion
	final begin
		if (!verdict) begin
			$display("** FAIL **");
		end
	end

endmodule

`default_nettype wire

/* flist.f */
logic/core_pkg.sv
logic/mem_pkg.sv
logic/processor.sv
logic/l2_cache.sv
logic/bus_arbiter.sv
logic/dualcore.sv
verif/dualcore_props.sv
verif/dualcore_checker.sv
verif/dualcore_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dualcore_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ** PASS **

SOURCES := $(shell grep -v '^+' $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF -- "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
